/* sim.f */
+incdir+include
rtl/tlp_pkg.sv
rtl/crdt_pkg.sv
rtl/tlp_intake.sv
rtl/crdt_init_ctrl.sv
rtl/crdt_class_counter.sv
rtl/tx_crdt_tracker.sv
verif/tx_crdt_properties.sv
verif/tb_tx_crdt_tracker.sv

/* verif/tb_tx_crdt_tracker.sv */
//--------------------------------------------------------------------------
// testbench of the transmit credit tracker
// drives random init requests, grants and tlp headers, steps a reference
// model on every edge and compares counters, ready and acks with the DUT
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "crdt_params.svh"

module tb_tx_crdt_tracker;

   import tlp_pkg::*;
   import crdt_pkg::*;

   localparam int INIT_CYC    = 40;
   localparam int GRANT_CYC   = 40;
   localparam int TRAFFIC_CYC = 120;
   localparam int INF_CYC     = 4;
   localparam int TAIL_CYC    = 100;
   localparam int TOTAL_CYC   = 8 + INIT_CYC + 2 * INF_CYC + GRANT_CYC + TRAFFIC_CYC
                              + TAIL_CYC;
   localparam int TIMEOUT_NS  = (TOTAL_CYC + 20) * 40;
   // last entry is an undecoded type
   localparam logic [7:0] OPS [7] = '{MRD32, MRD64, MWR32, MWR64, CPL, CPLD, 8'h7F};

   // expected state of the tracker
   typedef struct packed {
      logic [2:0][`CRDT_HDR_W-1:0]  hdr;
      logic [2:0][`CRDT_DATA_W-1:0] data;
      logic [2:0]                   hdr_inf;
      logic [2:0]                   data_inf;
      logic                         ready;
      logic [5:0]                   init_q;
      logic [5:0]                   sent;
      logic [5:0]                   ack;
      logic                         cvalid;
      logic [1:0]                   ccls;
      logic [8:0]                   cdata;
   } model_t;

   logic                  clk;
   logic                  srst_reg;
   logic                  tlp_valid_i;
   tlp_hdr_t              tlp_hdr_i;
   logic                  tlp_ready_o;
   logic                  link_ready_i;
   crdt_update_t          crdt_update_i;
   crdt_init_t            crdt_init_i;
   crdt_init_t            crdt_init_ack_o;
   hdr_crdt_t  [2:0]      hdr_crdt_o;
   data_crdt_t [2:0]      data_crdt_o;
   model_t                exp_q;
   integer                seed;
   logic                  rdy_seen;
   int                    errors;
   int                    checks;

   tx_crdt_tracker uut (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // one edge of the tracker, from the inputs seen at that edge
   function automatic model_t step_model(model_t m, logic vld, logic link_rdy, tlp_hdr_t h,
                                         crdt_update_t u, crdt_init_t init);
      model_t n;
      logic   low;
      logic   hit;
      n = m;
      low = 1'b0;
      for (int c = 0; c < 3; c++) begin
         low = low || (m.hdr[c] < `CRDT_LOW_MARK && !m.hdr_inf[c])
                   || (m.data[c] < `CRDT_LOW_MARK && !m.data_inf[c]);
         hit = m.cvalid && (m.ccls == c);
         n.hdr[c]  = m.hdr[c] - hit + (u.hdr_upd[c] ? u.hdr_cnt[c] : 0);
         n.data[c] = m.data[c] - (hit ? m.cdata : 0) + (u.data_upd[c] ? u.data_cnt[c] : 0);
         if (u.hdr_upd[c] && m.init_q[3+c] && u.hdr_cnt[c] == 0) begin
            n.hdr_inf[c] = 1'b1;
         end
         if (u.data_upd[c] && m.init_q[c] && u.data_cnt[c] == 0) begin
            n.data_inf[c] = 1'b1;
         end
      end
      n.ready  = link_rdy && !low;
      n.ack    = m.init_q & ~m.sent;
      n.sent   = m.init_q;
      n.init_q = init;
      n.cvalid = vld && m.ready;
      n.cdata  = 0;
      case (h.fmt_type)
         MWR32, MWR64: begin
            n.ccls  = 2'd0;
            n.cdata = (h.length + 3) >> 2;
         end
         MRD32, MRD64: n.ccls = 2'd1;
         CPL:          n.ccls = 2'd2;
         CPLD: begin
            n.ccls  = 2'd2;
            n.cdata = (h.length + 3) >> 2;
         end
         default:      n.cvalid = 1'b0;
      endcase
      return n;
   endfunction

   task automatic check_value(string name, logic [31:0] expv, logic [31:0] obsv);
      checks++;
      assert (expv === obsv) else begin
         errors++;
         $display("MISMATCH %s expected %0h observed %0h at %0t", name, expv, obsv, $time);
      end
   endtask

   always @(posedge clk) begin
      if (srst_reg) begin
         exp_q = '0;
      end else begin
         exp_q = step_model(exp_q, tlp_valid_i, link_ready_i, tlp_hdr_i, crdt_update_i,
                            crdt_init_i);
         #1;
         check_value("tlp_ready_o", exp_q.ready, tlp_ready_o);
         check_value("crdt_init_ack_o", exp_q.ack, crdt_init_ack_o);
         for (int c = 0; c < 3; c++) begin
            check_value($sformatf("hdr_crdt_o[%0d]", c), exp_q.hdr[c], hdr_crdt_o[c]);
            check_value($sformatf("data_crdt_o[%0d]", c), exp_q.data[c], data_crdt_o[c]);
         end
      end
   end

   // mode 0 init toggling, 1 grants, 2 traffic, 3 zero-count grants under init
   task automatic drive_cycle(input int mode);
      logic        accepted;
      logic [31:0] r;
      @(posedge clk);
      #2;
      accepted = tlp_valid_i && rdy_seen;
      rdy_seen = tlp_ready_o;
      r = $random(seed);
      crdt_update_i = $random(seed);
      link_ready_i = (r[3:2] != 2'b00);
      case (mode)
         0: begin
            crdt_update_i = '0;
            if (r[7:5] == 3'd0) begin
               crdt_init_i[r[10:8] % 6] = ~crdt_init_i[r[10:8] % 6];
            end
         end
         1: crdt_init_i = '0;
         2: begin
            crdt_init_i = '0;
            crdt_update_i.hdr_upd  &= r[13:11];
            crdt_update_i.data_upd &= r[16:14];
         end
         default: begin
            crdt_init_i = '1;
            crdt_update_i = '0;
            link_ready_i = 1'b1;
            crdt_update_i.hdr_upd[CLS_P]   = 1'b1;
            crdt_update_i.data_upd[CLS_P]  = 1'b1;
            crdt_update_i.data_upd[CLS_NP] = 1'b1;
            // the finite counters fill by one credit per cycle
            crdt_update_i.hdr_upd[CLS_NP]   = 1'b1;
            crdt_update_i.hdr_cnt[CLS_NP]   = 2'd1;
            crdt_update_i.hdr_upd[CLS_CPL]  = 1'b1;
            crdt_update_i.hdr_cnt[CLS_CPL]  = 2'd1;
            crdt_update_i.data_upd[CLS_CPL] = 1'b1;
            crdt_update_i.data_cnt[CLS_CPL] = 4'd1;
         end
      endcase
      // a pending header stays untouched until taken
      if (!tlp_valid_i || accepted) begin
         tlp_valid_i = (mode == 2) && r[0];
         tlp_hdr_i.fmt_type = OPS[r[20:18] % 7];
         tlp_hdr_i.length = r[26:22];
      end
   endtask

   initial begin
      seed = 32'hc7f6477c;
      errors = 0;
      checks = 0;
      srst_reg = 1'b1;
      tlp_valid_i = 1'b0;
      tlp_hdr_i = '0;
      link_ready_i = 1'b0;
      crdt_update_i = '0;
      crdt_init_i = '0;
      rdy_seen = 1'b0;
      repeat (8) @(posedge clk);
      #2 srst_reg = 1'b0;
      repeat (INIT_CYC) drive_cycle(0);
      // infinite counters still empty, so ready depends on the flags
      repeat (INF_CYC) drive_cycle(3);
      repeat (GRANT_CYC) drive_cycle(1);
      repeat (TRAFFIC_CYC) drive_cycle(2);
      repeat (INF_CYC) drive_cycle(3);
      repeat (TAIL_CYC) drive_cycle(2);
      @(posedge clk);
      #5;
      $display("checks %0d, mismatches %0d, assertion failures %0d",
               checks, errors, uut.u_props.fail_cnt);
      if (errors == 0 && uut.u_props.fail_cnt == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("timeout, stimulus did not complete within %0d ns", TIMEOUT_NS);
      $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

/* verif/tx_crdt_properties.sv */
//--------------------------------------------------------------------------
// concurrent checks on the credit tracker, bound into the top level
// covers the tlp handshake and the init acknowledges
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tx_crdt_properties (
   input wire logic                 clk,
   input wire logic                 srst_reg,
   input wire logic                 tlp_valid_i,
   input wire tlp_pkg::tlp_hdr_t    tlp_hdr_i,
   input wire logic                 tlp_ready_o,
   input wire crdt_pkg::crdt_init_t crdt_init_ack_o,
   input wire crdt_pkg::crdt_init_t init_active
);

   int fail_cnt;

   initial begin
      fail_cnt = 0;
   end

   // every ack bit is a single-cycle pulse
   ack_one_cycle: assert property (@(posedge clk) disable iff (srst_reg)
      (crdt_init_ack_o & $past(crdt_init_ack_o)) == '0)
   else begin
      fail_cnt++;
      $error("init acknowledge held for more than one cycle");
   end

   // an ack follows the registered request that caused it
   ack_needs_init: assert property (@(posedge clk) disable iff (srst_reg)
      (crdt_init_ack_o & ~$past(init_active)) == '0)
   else begin
      fail_cnt++;
      $error("init acknowledge without an active init request");
   end

   valid_held: assert property (@(posedge clk) disable iff (srst_reg)
      (tlp_valid_i && !tlp_ready_o) |=> (tlp_valid_i && $stable(tlp_hdr_i)))
   else begin
      fail_cnt++;
      $error("tlp valid or header changed before acceptance");
   end

   ready_low_after_reset: assert property (@(posedge clk)
      $fell(srst_reg) |-> !tlp_ready_o)
   else begin
      fail_cnt++;
      $error("tlp ready high in the first cycle after reset");
   end

endmodule

bind tx_crdt_tracker tx_crdt_properties u_props (
   .clk             (clk),
   .srst_reg        (srst_reg),
   .tlp_valid_i     (tlp_valid_i),
   .tlp_hdr_i       (tlp_hdr_i),
   .tlp_ready_o     (tlp_ready_o),
   .crdt_init_ack_o (crdt_init_ack_o),
   .init_active     (init_active)
);

`default_nettype wire

/* rtl/tx_crdt_tracker.sv */
//--------------------------------------------------------------------------
// transmit credit tracker, top level
// joins the tlp intake, the init handshake and one counter pair per flow
// control class; grant and init records are split per class here
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "crdt_params.svh"

module tx_crdt_tracker (
   input  wire logic                                        clk,
   input  wire logic                                        srst_reg,
   input  wire logic                                        tlp_valid_i,
   input  wire tlp_pkg::tlp_hdr_t                           tlp_hdr_i,
   output logic                                             tlp_ready_o,
   input  wire logic                                        link_ready_i,
   input  wire crdt_pkg::crdt_update_t                      crdt_update_i,
   input  wire crdt_pkg::crdt_init_t                        crdt_init_i,
   output crdt_pkg::crdt_init_t                             crdt_init_ack_o,
   output crdt_pkg::hdr_crdt_t  [`NUM_CRDT_CLASSES-1:0]     hdr_crdt_o,
   output crdt_pkg::data_crdt_t [`NUM_CRDT_CLASSES-1:0]     data_crdt_o
);

   import tlp_pkg::*;
   import crdt_pkg::*;

   tlp_consume_t                   consume;
   crdt_init_t                     init_active;
   logic [`NUM_CRDT_CLASSES-1:0]   crdt_low;

   tlp_intake u_intake (
      .clk          (clk),
      .srst_reg     (srst_reg),
      .tlp_valid_i  (tlp_valid_i),
      .tlp_hdr_i    (tlp_hdr_i),
      .link_ready_i (link_ready_i),
      .crdt_low_i   (crdt_low),
      .tlp_ready_o  (tlp_ready_o),
      .consume_o    (consume)
   );

   crdt_init_ctrl u_init_ctrl (
      .clk             (clk),
      .srst_reg        (srst_reg),
      .crdt_init_i     (crdt_init_i),
      .init_active_o   (init_active),
      .crdt_init_ack_o (crdt_init_ack_o)
   );

   // one counter pair per class, index equals the class encoding
   for (genvar g = 0; g < `NUM_CRDT_CLASSES; g++) begin : g_class
      crdt_class_counter #(
         .CLASS (crdt_class_e'(g))
      ) u_counter (
         .clk            (clk),
         .srst_reg       (srst_reg),
         .consume_i      (consume),
         .hdr_upd_i      (crdt_update_i.hdr_upd[g]),
         .hdr_upd_cnt_i  (crdt_update_i.hdr_cnt[g]),
         .data_upd_i     (crdt_update_i.data_upd[g]),
         .data_upd_cnt_i (crdt_update_i.data_cnt[g]),
         .hdr_init_i     (init_active.hdr[g]),
         .data_init_i    (init_active.data[g]),
         .hdr_crdt_o     (hdr_crdt_o[g]),
         .data_crdt_o    (data_crdt_o[g]),
         .crdt_low_o     (crdt_low[g])
      );
   end

endmodule

`default_nettype wire

/* rtl/crdt_class_counter.sv */
//--------------------------------------------------------------------------
// header and data credit counters of one flow control class
// consumption and grants of the same edge are combined into one update;
// a zero-count grant during init marks the counter infinite until reset
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "crdt_params.svh"

module crdt_class_counter #(
   parameter crdt_pkg::crdt_class_e CLASS = crdt_pkg::CLS_P
) (
   input  wire logic                     clk,
   input  wire logic                     srst_reg,
   input  wire tlp_pkg::tlp_consume_t    consume_i,
   input  wire logic                     hdr_upd_i,
   input  wire logic [`HDR_UPD_W-1:0]    hdr_upd_cnt_i,
   input  wire logic                     data_upd_i,
   input  wire logic [`DATA_UPD_W-1:0]   data_upd_cnt_i,
   input  wire logic                     hdr_init_i,
   input  wire logic                     data_init_i,
   output crdt_pkg::hdr_crdt_t           hdr_crdt_o,
   output crdt_pkg::data_crdt_t          data_crdt_o,
   output logic                          crdt_low_o
);

   import crdt_pkg::*;

   logic        hit;
   hdr_crdt_t   hdr_sub;
   hdr_crdt_t   hdr_add;
   data_crdt_t  data_sub;
   data_crdt_t  data_add;
   logic        hdr_inf;
   logic        data_inf;

   // consume record addressed to this class
   assign hit = consume_i.valid & (consume_i.cls == CLASS);

   assign hdr_sub  = hit ? hdr_crdt_t'(1) : '0;
   assign data_sub = hit ? data_crdt_t'(consume_i.data_crdt) : '0;
   assign hdr_add  = hdr_upd_i ? hdr_crdt_t'(hdr_upd_cnt_i) : '0;
   assign data_add = data_upd_i ? data_crdt_t'(data_upd_cnt_i) : '0;

   //------------------------------------------------------------------------
   // counters
   //------------------------------------------------------------------------
   always_ff @(posedge clk or posedge srst_reg) begin
      if (srst_reg) begin
         hdr_crdt_o  <= '0;
         data_crdt_o <= '0;
      end else begin
         hdr_crdt_o  <= hdr_crdt_o - hdr_sub + hdr_add;
         data_crdt_o <= data_crdt_o - data_sub + data_add;
      end
   end

   //------------------------------------------------------------------------
   // infinite flags, sticky until reset
   //------------------------------------------------------------------------
   always_ff @(posedge clk or posedge srst_reg) begin
      if (srst_reg) begin
         hdr_inf  <= 1'b0;
         data_inf <= 1'b0;
      end else begin
         if (hdr_upd_i && hdr_init_i && (hdr_upd_cnt_i == '0)) begin
            hdr_inf <= 1'b1;
         end
         if (data_upd_i && data_init_i && (data_upd_cnt_i == '0)) begin
            data_inf <= 1'b1;
         end
      end
   end

   // an infinite counter never holds back the intake
   assign crdt_low_o = ((hdr_crdt_o < `CRDT_LOW_MARK) && !hdr_inf)
                    || ((data_crdt_o < `CRDT_LOW_MARK) && !data_inf);

endmodule

`default_nettype wire

/* rtl/crdt_init_ctrl.sv */
//--------------------------------------------------------------------------
// credit init handshake
// registers the six init requests and returns one acknowledge pulse per
// credit type for each rising request; the registered requests also
// qualify infinite-credit detection in the counters
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "crdt_params.svh"

module crdt_init_ctrl (
   input  wire logic              clk,
   input  wire logic              srst_reg,
   input  wire crdt_pkg::crdt_init_t crdt_init_i,
   output crdt_pkg::crdt_init_t   init_active_o,
   output crdt_pkg::crdt_init_t   crdt_init_ack_o
);

   import crdt_pkg::*;

   localparam int NUM_TYPES = 2 * `NUM_CRDT_CLASSES;

   crdt_init_t             init_q;
   logic [NUM_TYPES-1:0]   req_vec;
   logic [NUM_TYPES-1:0]   ack_vec;
   crdt_ack_state_e        ack_state [NUM_TYPES];

   // header types in the upper half, data types in the lower half
   assign req_vec = init_q;

   always_ff @(posedge clk or posedge srst_reg) begin
      if (srst_reg) begin
         init_q  <= '0;
         ack_vec <= '0;
         for (int i = 0; i < NUM_TYPES; i++) begin
            ack_state[i] <= ACK_ARMED;
         end
      end else begin
         init_q <= crdt_init_i;
         for (int i = 0; i < NUM_TYPES; i++) begin
            ack_vec[i] <= 1'b0;
            if (req_vec[i]) begin
               // first cycle of a held request
               if (ack_state[i] == ACK_ARMED) begin
                  ack_vec[i]   <= 1'b1;
                  ack_state[i] <= ACK_SENT;
               end
            end else begin
               ack_state[i] <= ACK_ARMED;
            end
         end
      end
   end

   assign init_active_o   = init_q;
   assign crdt_init_ack_o = ack_vec;

endmodule

`default_nettype wire

/* rtl/tlp_intake.sv */
//--------------------------------------------------------------------------
// tlp header intake of the credit tracker
// accepts headers on valid/ready, decodes the class and data credits and
// registers one consume record per accepted header; ready is withdrawn
// while any class reports a finite counter under the low-water mark
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "crdt_params.svh"

module tlp_intake (
   input  wire logic                          clk,
   input  wire logic                          srst_reg,
   input  wire logic                          tlp_valid_i,
   input  wire tlp_pkg::tlp_hdr_t             tlp_hdr_i,
   input  wire logic                          link_ready_i,
   input  wire logic [`NUM_CRDT_CLASSES-1:0]  crdt_low_i,
   output logic                               tlp_ready_o,
   output tlp_pkg::tlp_consume_t              consume_o
);

   import tlp_pkg::*;
   import crdt_pkg::*;

   logic                                       accept;
   logic                                       dec_known;
   crdt_class_e                                dec_cls;
   logic [`TLP_LEN_W-`DW_PER_DATA_CRDT_LOG2:0] len_crdt;
   logic [`TLP_LEN_W-`DW_PER_DATA_CRDT_LOG2:0] dec_data;

   assign accept = tlp_valid_i & tlp_ready_o;

   // dwords to credits, rounded up
   assign len_crdt = {1'b0, tlp_hdr_i.length[`TLP_LEN_W-1:`DW_PER_DATA_CRDT_LOG2]}
                   + (|tlp_hdr_i.length[`DW_PER_DATA_CRDT_LOG2-1:0]);

   always_comb begin
      dec_known = 1'b1;
      dec_cls   = CLS_P;
      dec_data  = '0;
      case (tlp_hdr_i.fmt_type)
         MWR32, MWR64: begin
            dec_cls  = CLS_P;
            dec_data = len_crdt;
         end
         // reads carry no payload
         MRD32, MRD64: dec_cls = CLS_NP;
         CPL:          dec_cls = CLS_CPL;
         CPLD: begin
            dec_cls  = CLS_CPL;
            dec_data = len_crdt;
         end
         default:      dec_known = 1'b0;
      endcase
   end

   always_ff @(posedge clk or posedge srst_reg) begin
      if (srst_reg) begin
         consume_o   <= '0;
         tlp_ready_o <= 1'b0;
      end else begin
         consume_o.valid     <= accept & dec_known;
         consume_o.cls       <= dec_cls;
         consume_o.data_crdt <= dec_data;
         // back-pressure from any low class
         tlp_ready_o         <= link_ready_i & ~(|crdt_low_i);
      end
   end

endmodule

`default_nettype wire

/* rtl/crdt_pkg.sv */
//--------------------------------------------------------------------------
// credit side types of the tracker
// flow control classes, grant and init records from the link partner,
// counter types and the per-type acknowledge state
//--------------------------------------------------------------------------

`default_nettype none

`include "crdt_params.svh"

package crdt_pkg;

   // flow control classes, index into the per-class vectors
   typedef enum logic [1:0] {
      CLS_P   = 2'd0,
      CLS_NP  = 2'd1,
      CLS_CPL = 2'd2
   } crdt_class_e;

   // grant strobes and counts, one lane per class
   typedef struct packed {
      logic [`NUM_CRDT_CLASSES-1:0]                  hdr_upd;
      logic [`NUM_CRDT_CLASSES-1:0][`HDR_UPD_W-1:0]  hdr_cnt;
      logic [`NUM_CRDT_CLASSES-1:0]                  data_upd;
      logic [`NUM_CRDT_CLASSES-1:0][`DATA_UPD_W-1:0] data_cnt;
   } crdt_update_t;

   // init requests, also used for the acknowledges
   typedef struct packed {
      logic [`NUM_CRDT_CLASSES-1:0] hdr;
      logic [`NUM_CRDT_CLASSES-1:0] data;
   } crdt_init_t;

   typedef logic [`CRDT_HDR_W-1:0]  hdr_crdt_t;
   typedef logic [`CRDT_DATA_W-1:0] data_crdt_t;

   typedef enum logic {ACK_ARMED, ACK_SENT} crdt_ack_state_e;

endpackage

`default_nettype wire

/* rtl/tlp_pkg.sv */
//--------------------------------------------------------------------------
// tlp side types of the credit tracker
// opcode encoding, the header seen at the intake and the consume record
// that the intake hands to the class counters
//--------------------------------------------------------------------------

`default_nettype none

`include "crdt_params.svh"

package tlp_pkg;

   // fmt/type byte of the decoded tlp kinds
   typedef enum logic [7:0] {
      MRD32 = 8'h00,
      MRD64 = 8'h20,
      MWR32 = 8'h40,
      MWR64 = 8'h60,
      CPL   = 8'h0A,
      CPLD  = 8'h4A
   } tlp_fmt_type_e;

   // fmt/type byte plus length in dwords
   typedef struct packed {
      logic [7:0]            fmt_type;
      logic [`TLP_LEN_W-1:0] length;
   } tlp_hdr_t;

   // one accepted header, already turned into credits
   typedef struct packed {
      logic                                              valid;
      logic [1:0]                                        cls;
      logic [`TLP_LEN_W-`DW_PER_DATA_CRDT_LOG2:0]        data_crdt;
   } tlp_consume_t;

endpackage

`default_nettype wire

/* include/crdt_params.svh */
//--------------------------------------------------------------------------
// widths and thresholds of the transmit credit tracker
// included by the packages and by every module that sizes a port with them
//--------------------------------------------------------------------------

`ifndef CRDT_PARAMS_SVH
`define CRDT_PARAMS_SVH

// counter widths
`define CRDT_HDR_W             13
`define CRDT_DATA_W            16

// tlp length field in dwords, and grant count widths per class
`define TLP_LEN_W              10
`define HDR_UPD_W              2
`define DATA_UPD_W             4

`define NUM_CRDT_CLASSES       3
`define CRDT_LOW_MARK          3
// one data credit covers four dwords
`define DW_PER_DATA_CRDT_LOG2  2

`endif
